//--- src/led_defs.svh
`ifndef LED_DEFS_SVH
`define LED_DEFS_SVH

// Frame buffer and prescaler sizes
`define LED_RAM_AW        10
`define LED_PSIZE         16
`define LED_CNT_W         4

// Wishbone widths and decode
`define LED_WB_AW         32
`define LED_WB_DW         32
`define LED_MEM_SEL_BIT   12
`define LED_MEM_LAT       4

// Register bit positions
`define LED_CFG_EN_BIT    31
`define LED_CFG_IRQ_BIT   30
`define LED_CFG_IDLE_BIT  29
`define LED_CTRL_GO_BIT   31
`define LED_CTRL_STB_BIT  30
`define LED_CTRL_PROG_BIT 29
`define LED_CTRL_CNT_LSB  25
`define LED_CTRL_LAST_LSB 12

// Bit period in prescaler ticks
`define LED_T_ZERO        8
`define LED_T_ONE         16
`define LED_T_BIT         24

`endif

//--- src/led_pkg.sv
`include "led_defs.svh"

package led_pkg;

  // Static configuration, driven from the CONFIG/MULT/DIV registers
  typedef struct packed {
    logic                  enable;
    logic                  irq_en;
    logic                  idle_level;
    logic [`LED_PSIZE-1:0] multiplier;
    logic [`LED_PSIZE-1:0] divider;
  } led_cfg_t;

  // Sequence range and extra passes
  typedef struct packed {
    logic [`LED_CNT_W-1:0]  count;
    logic [`LED_RAM_AW-1:0] last;
    logic [`LED_RAM_AW-1:0] first;
  } seq_cmd_t;

  // One bit handed to the encoder
  typedef struct packed {
    logic valid;
    logic value;
  } led_bit_t;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_FETCH,   // RAM select
    SEQ_WAIT,    // Read data registered
    SEQ_LOAD,    // Byte captured
    SEQ_SEND
  } seq_state_e;

  typedef enum logic [1:0] {
    REG_CONFIG = 2'd0,
    REG_MULT   = 2'd1,
    REG_DIV    = 2'd2,
    REG_CTRL   = 2'd3
  } reg_idx_e;

endpackage

//--- src/led_prescaler.sv
`include "led_defs.svh"

module led_prescaler (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clear_n_i,
  input  logic [`LED_PSIZE-1:0] multiplier_i,
  input  logic [`LED_PSIZE-1:0] divider_i,
  output logic                  tick_o
);

  logic [`LED_PSIZE-1:0] acc;
  logic [`LED_PSIZE:0]   sum;
  logic [`LED_PSIZE:0]   rem;
  logic [`LED_PSIZE:0]   div_ext;

  // One extra bit so the sum never wraps
  assign div_ext = {1'b0, divider_i};
  assign sum     = {1'b0, acc} + {1'b0, multiplier_i};
  assign rem     = sum - div_ext;

  // Tick in every cycle where the sum reaches the divider
  assign tick_o = (sum >= div_ext);

  always_ff @(posedge clk) begin
    if (!rst_n || !clear_n_i) begin
      acc <= '0;
    end else if (tick_o) begin
      // Rates above one tick per cycle saturate
      if (rem >= div_ext) begin
        acc <= '0;
      end else begin
        acc <= rem[`LED_PSIZE-1:0];
      end
    end else begin
      acc <= sum[`LED_PSIZE-1:0];
    end
  end

endmodule

//--- src/led_bit_encoder.sv
`include "led_defs.svh"

module led_bit_encoder (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clear_n_i,
  input  logic              tick_i,
  input  logic              idle_level_i,
  input  led_pkg::led_bit_t bit_req_i,
  output logic              ready_o,
  output logic              sout_o
);

  localparam logic [4:0] T_ZERO = 5'(`LED_T_ZERO);
  localparam logic [4:0] T_ONE  = 5'(`LED_T_ONE);
  localparam logic [4:0] T_BIT  = 5'(`LED_T_BIT);

  logic [4:0] count;   // Rests at T_BIT between bits
  logic       dbit;
  logic       polar;
  logic       accept;
  logic       active;

  assign accept = tick_i && (count == T_BIT) && bit_req_i.valid;
  assign active = (count < (dbit ? T_ONE : T_ZERO));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count   <= T_BIT;
      ready_o <= 1'b0;
      dbit    <= 1'b0;
      polar   <= 1'b0;
      sout_o  <= 1'b0;
    end else if (!clear_n_i) begin
      // Disabled line sits at the programmed idle level
      count   <= T_BIT;
      ready_o <= 1'b0;
      dbit    <= 1'b0;
      polar   <= idle_level_i;
      sout_o  <= idle_level_i;
    end else begin
      ready_o <= accept;
      if (accept) begin
        count <= '0;
        dbit  <= bit_req_i.value;
        polar <= idle_level_i;
      end else if (count == T_BIT) begin
        polar <= idle_level_i;       // Follow idle level while resting
      end else if (tick_i) begin
        count <= count + 5'd1;
      end
      sout_o <= active ? ~polar : polar;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // An offered bit is not withdrawn before it is taken
  a_valid_held: assert property (
    @(posedge clk) disable iff (!rst_n || !clear_n_i)
    bit_req_i.valid && !ready_o |=> bit_req_i.valid
  );

endmodule

//--- src/led_sequencer.sv
`include "led_defs.svh"

module led_sequencer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   clear_n_i,
  input  led_pkg::seq_cmd_t      cmd_i,
  input  logic                   start_i,
  output logic                   progress_o,
  output logic                   ram_cs_o,
  output logic [`LED_RAM_AW-1:0] ram_addr_o,
  input  logic [7:0]             ram_rdata_i,
  output led_pkg::led_bit_t      bit_req_o,
  input  logic                   ready_i
);

  led_pkg::seq_state_e    state;
  logic [2:0]             bit_idx;
  logic [7:0]             data;
  logic [`LED_RAM_AW-1:0] first_addr;
  logic [`LED_RAM_AW-1:0] last_addr;
  logic [`LED_CNT_W-1:0]  passes;     // Passes left after this one
  logic                   byte_done;

  assign byte_done = (state == led_pkg::SEQ_SEND) && ready_i && (bit_idx == 3'd0);

  always_ff @(posedge clk) begin
    if (!rst_n || !clear_n_i) begin
      state   <= led_pkg::SEQ_IDLE;
      bit_idx <= '0;
      passes  <= '0;
    end else begin
      case (state)
        led_pkg::SEQ_IDLE: begin
          if (start_i) begin
            state  <= led_pkg::SEQ_FETCH;
            passes <= cmd_i.count;
          end
        end
        led_pkg::SEQ_FETCH: state <= led_pkg::SEQ_WAIT;
        led_pkg::SEQ_WAIT:  state <= led_pkg::SEQ_LOAD;
        led_pkg::SEQ_LOAD: begin
          state   <= led_pkg::SEQ_SEND;
          bit_idx <= 3'd7;                    // MSB first
        end
        led_pkg::SEQ_SEND: begin
          if (ready_i) begin
            if (bit_idx != 3'd0) begin
              bit_idx <= bit_idx - 3'd1;
            end else if (ram_addr_o != last_addr) begin
              state <= led_pkg::SEQ_FETCH;
            end else if (passes == '0) begin
              state <= led_pkg::SEQ_IDLE;
            end else begin
              passes <= passes - 1'b1;
              state  <= led_pkg::SEQ_FETCH;
            end
          end
        end
        default: state <= led_pkg::SEQ_IDLE;
      endcase
    end
  end

  // Range bounds, address and current byte
  always_ff @(posedge clk) begin
    if ((state == led_pkg::SEQ_IDLE) && start_i) begin
      first_addr <= cmd_i.first;
      last_addr  <= cmd_i.last;
      ram_addr_o <= cmd_i.first;
    end else if (byte_done) begin
      ram_addr_o <= (ram_addr_o == last_addr) ? first_addr : ram_addr_o + 1'b1;
    end
    if (state == led_pkg::SEQ_LOAD) begin
      data <= ram_rdata_i;
    end
  end

  assign ram_cs_o   = (state == led_pkg::SEQ_FETCH);
  assign progress_o = (state != led_pkg::SEQ_IDLE);
  assign bit_req_o  = '{valid: (state == led_pkg::SEQ_SEND), value: data[bit_idx]};

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Encoder only answers a bit that is on offer
  a_cs_fetch: assert property (
    @(posedge clk) disable iff (!rst_n || !clear_n_i)
    ready_i |-> bit_req_o.valid
  );

  // Ready is a single-cycle pulse
  a_valid_hold: assert property (
    @(posedge clk) disable iff (!rst_n || !clear_n_i)
    ready_i |=> !ready_i
  );

endmodule

//--- src/led_frame_ram.sv
module led_frame_ram #(
  parameter int AW = 10,
  parameter int DW = 8
) (
  input  logic          clk,
  input  logic          cs0_i,
  input  logic          we0_i,
  input  logic [AW-1:0] addr0_i,
  input  logic [DW-1:0] wdata0_i,
  output logic [DW-1:0] rdata0_o,
  input  logic          cs1_i,
  input  logic [AW-1:0] addr1_i,
  output logic [DW-1:0] rdata1_o
);

  logic [DW-1:0] mem [0:(1<<AW)-1];

  // Bus port, read returns the old contents on a write
  always_ff @(posedge clk) begin
    if (cs0_i) begin
      if (we0_i) begin
        mem[addr0_i] <= wdata0_i;
      end
      rdata0_o <= mem[addr0_i];
    end
  end

  // Sequencer port
  always_ff @(posedge clk) begin
    if (cs1_i) begin
      rdata1_o <= mem[addr1_i];
    end
  end

endmodule

//--- src/led_registers.sv
`include "led_defs.svh"

module led_registers (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wbs_cyc_i,
  input  logic                   wbs_stb_i,
  input  logic                   wbs_we_i,
  input  logic [`LED_WB_AW-1:0]  wbs_adr_i,
  input  logic [`LED_WB_DW-1:0]  wbs_dat_i,
  input  logic [3:0]             wbs_sel_i,
  output logic [`LED_WB_DW-1:0]  wbs_dat_o,
  output logic                   wbs_ack_o,
  output logic                   irq_o,
  output led_pkg::led_cfg_t      cfg_o,
  output led_pkg::seq_cmd_t      cmd_o,
  output logic                   start_o,
  input  logic                   progress_i,
  output logic                   ram_cs_o,
  output logic                   ram_we_o,
  output logic [`LED_RAM_AW-1:0] ram_addr_o,
  output logic [7:0]             ram_wdata_o,
  input  logic [7:0]             ram_rdata_i
);

  localparam logic [1:0] MEM_LAST = 2'(`LED_MEM_LAT - 1);

  logic              req;
  logic              reg_sel;
  logic              reg_wr;
  logic [1:0]        mem_phase;
  logic              progress_q;
  led_pkg::reg_idx_e reg_idx;

  assign req     = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;    // New request only
  assign reg_sel = !wbs_adr_i[`LED_MEM_SEL_BIT];
  assign reg_wr  = req && reg_sel && wbs_we_i && (|wbs_sel_i);
  assign reg_idx = led_pkg::reg_idx_e'(wbs_adr_i[3:2]);

  ////////////////////////////////////////////////////////////////////////////
  // Bus timing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wbs_ack_o <= 1'b0;
      mem_phase <= '0;
      ram_cs_o  <= 1'b0;
      ram_we_o  <= 1'b0;
    end else begin
      wbs_ack_o <= 1'b0;
      ram_cs_o  <= 1'b0;
      ram_we_o  <= 1'b0;
      if (req && reg_sel) begin
        wbs_ack_o <= 1'b1;                              // Registers answer at once
        mem_phase <= '0;
      end else if (req) begin
        mem_phase <= (mem_phase == MEM_LAST) ? 2'd0 : mem_phase + 2'd1;
        if (mem_phase == 2'd0) begin
          ram_cs_o <= 1'b1;
          ram_we_o <= wbs_we_i && wbs_sel_i[0];
        end
        if (mem_phase == MEM_LAST) begin
          wbs_ack_o <= 1'b1;
        end
      end else begin
        mem_phase <= '0;
      end
    end
  end

  // Byte lane 0 carries the frame buffer data
  always_ff @(posedge clk) begin
    if (req && !reg_sel && (mem_phase == 2'd0)) begin
      ram_addr_o  <= wbs_adr_i[`LED_RAM_AW+1:2];
      ram_wdata_o <= wbs_dat_i[7:0];
    end
  end

  // Read data, valid together with ack
  always_ff @(posedge clk) begin
    if (req && reg_sel) begin
      wbs_dat_o <= '0;
      case (reg_idx)
        led_pkg::REG_CONFIG: begin
          wbs_dat_o[`LED_CFG_EN_BIT]   <= cfg_o.enable;
          wbs_dat_o[`LED_CFG_IRQ_BIT]  <= cfg_o.irq_en;
          wbs_dat_o[`LED_CFG_IDLE_BIT] <= cfg_o.idle_level;
        end
        led_pkg::REG_MULT: wbs_dat_o[`LED_PSIZE-1:0] <= cfg_o.multiplier;
        led_pkg::REG_DIV:  wbs_dat_o[`LED_PSIZE-1:0] <= cfg_o.divider;
        led_pkg::REG_CTRL: begin
          wbs_dat_o[`LED_CTRL_STB_BIT]                 <= start_o;
          wbs_dat_o[`LED_CTRL_PROG_BIT]                <= progress_i;
          wbs_dat_o[`LED_CTRL_CNT_LSB +: `LED_CNT_W]   <= cmd_o.count;
          wbs_dat_o[`LED_CTRL_LAST_LSB +: `LED_RAM_AW] <= cmd_o.last;
          wbs_dat_o[`LED_RAM_AW-1:0]                   <= cmd_o.first;
        end
      endcase
    end else if (req && (mem_phase == MEM_LAST)) begin
      wbs_dat_o <= {{(`LED_WB_DW-8){1'b0}}, ram_rdata_i};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register file, start strobe and interrupt
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_o   <= '0;
      cmd_o   <= '0;
      start_o <= 1'b0;
    end else begin
      start_o <= reg_wr && (reg_idx == led_pkg::REG_CTRL) && wbs_dat_i[`LED_CTRL_GO_BIT];
      if (reg_wr) begin
        case (reg_idx)
          led_pkg::REG_CONFIG: begin
            cfg_o.enable     <= wbs_dat_i[`LED_CFG_EN_BIT];
            cfg_o.irq_en     <= wbs_dat_i[`LED_CFG_IRQ_BIT];
            cfg_o.idle_level <= wbs_dat_i[`LED_CFG_IDLE_BIT];
          end
          led_pkg::REG_MULT: cfg_o.multiplier <= wbs_dat_i[`LED_PSIZE-1:0];
          led_pkg::REG_DIV:  cfg_o.divider    <= wbs_dat_i[`LED_PSIZE-1:0];
          led_pkg::REG_CTRL: begin
            cmd_o.count <= wbs_dat_i[`LED_CTRL_CNT_LSB +: `LED_CNT_W];
            cmd_o.last  <= wbs_dat_i[`LED_CTRL_LAST_LSB +: `LED_RAM_AW];
            cmd_o.first <= wbs_dat_i[`LED_RAM_AW-1:0];
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      progress_q <= 1'b0;
      irq_o      <= 1'b0;
    end else begin
      progress_q <= progress_i;
      irq_o      <= cfg_o.irq_en && progress_q && !progress_i;   // End of sequence
    end
  end

  // Ack only answers a cycle the master still holds
  a_ack_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    wbs_ack_o |-> wbs_cyc_i && wbs_stb_i
  );

endmodule

//--- src/string_led_controller.sv
`include "led_defs.svh"

module string_led_controller (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wbs_cyc_i,
  input  logic                  wbs_stb_i,
  input  logic                  wbs_we_i,
  input  logic [`LED_WB_AW-1:0] wbs_adr_i,
  input  logic [`LED_WB_DW-1:0] wbs_dat_i,
  input  logic [3:0]            wbs_sel_i,
  output logic [`LED_WB_DW-1:0] wbs_dat_o,
  output logic                  wbs_ack_o,
  output logic                  irq_o,
  output logic                  sout_o
);

  led_pkg::led_cfg_t      cfg;
  led_pkg::seq_cmd_t      cmd;
  led_pkg::led_bit_t      bit_req;
  logic                   start;
  logic                   progress;
  logic                   tick;
  logic                   ready;

  // Frame buffer ports
  logic                   cs0;
  logic                   we0;
  logic [`LED_RAM_AW-1:0] addr0;
  logic [7:0]             wdata0;
  logic [7:0]             rdata0;
  logic                   cs1;
  logic [`LED_RAM_AW-1:0] addr1;
  logic [7:0]             rdata1;

  led_registers led_registers_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wbs_cyc_i   (wbs_cyc_i),
    .wbs_stb_i   (wbs_stb_i),
    .wbs_we_i    (wbs_we_i),
    .wbs_adr_i   (wbs_adr_i),
    .wbs_dat_i   (wbs_dat_i),
    .wbs_sel_i   (wbs_sel_i),
    .wbs_dat_o   (wbs_dat_o),
    .wbs_ack_o   (wbs_ack_o),
    .irq_o       (irq_o),
    .cfg_o       (cfg),
    .cmd_o       (cmd),
    .start_o     (start),
    .progress_i  (progress),
    .ram_cs_o    (cs0),
    .ram_we_o    (we0),
    .ram_addr_o  (addr0),
    .ram_wdata_o (wdata0),
    .ram_rdata_i (rdata0)
  );

  led_frame_ram #(
    .AW (`LED_RAM_AW),
    .DW (8)
  ) led_frame_ram_i (
    .clk      (clk),
    .cs0_i    (cs0),
    .we0_i    (we0),
    .addr0_i  (addr0),
    .wdata0_i (wdata0),
    .rdata0_o (rdata0),
    .cs1_i    (cs1),
    .addr1_i  (addr1),
    .rdata1_o (rdata1)
  );

  led_sequencer led_sequencer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_n_i   (cfg.enable),
    .cmd_i       (cmd),
    .start_i     (start),
    .progress_o  (progress),
    .ram_cs_o    (cs1),
    .ram_addr_o  (addr1),
    .ram_rdata_i (rdata1),
    .bit_req_o   (bit_req),
    .ready_i     (ready)
  );

  led_prescaler led_prescaler_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear_n_i    (cfg.enable),
    .multiplier_i (cfg.multiplier),
    .divider_i    (cfg.divider),
    .tick_o       (tick)
  );

  led_bit_encoder led_bit_encoder_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear_n_i    (cfg.enable),
    .tick_i       (tick),
    .idle_level_i (cfg.idle_level),
    .bit_req_i    (bit_req),
    .ready_o      (ready),
    .sout_o       (sout_o)
  );

endmodule

//--- test/tb_string_led_controller.sv
`include "led_defs.svh"

module tb_string_led_controller;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          BUS_TIMEOUT = 64;
  localparam int          POLL_LIMIT  = 20000;
  localparam int          RX_TIMEOUT  = 400000;    // Cycles
  localparam logic [31:0] MEM_BASE    = 32'h0000_1000;

  logic        clk;
  logic        rst_n;
  logic        wbs_cyc_i;
  logic        wbs_stb_i;
  logic        wbs_we_i;
  logic [31:0] wbs_adr_i;
  logic [31:0] wbs_dat_i;
  logic [3:0]  wbs_sel_i;
  logic [31:0] wbs_dat_o;
  logic        wbs_ack_o;
  logic        irq_o;
  logic        sout_o;

  logic [7:0] fb_model [0:(1<<`LED_RAM_AW)-1];   // Frame buffer model
  logic [7:0] rx_bytes [$];                       // Decoded from sout_o
  int         rx_pulses [$];                      // Active widths in cycles
  logic       decode_on;
  logic       line_idle;
  int         half_bit;                           // Zero/one threshold in cycles
  int         run_len;
  int         rx_nbits;
  logic [7:0] rx_shift;
  int         irq_count;
  int         checks;
  int         errors;

  string_led_controller string_led_controller_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_sel_i (wbs_sel_i),
    .wbs_dat_o (wbs_dat_o),
    .wbs_ack_o (wbs_ack_o),
    .irq_o     (irq_o),
    .sout_o    (sout_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Serial line decoder and interrupt counter
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!decode_on) begin
      run_len  = 0;
      rx_nbits = 0;
    end else if (sout_o != line_idle) begin
      run_len++;
    end else if (run_len != 0) begin
      rx_pulses.push_back(run_len);
      rx_shift = {rx_shift[6:0], (run_len > half_bit)};   // MSB arrives first
      rx_nbits++;
      if (rx_nbits == 8) begin
        rx_bytes.push_back(rx_shift);
        rx_nbits = 0;
      end
      run_len = 0;
    end
  end

  always @(posedge clk) begin
    if (rst_n && irq_o) begin
      irq_count++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking and bus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    checks++;
    if (exp_val !== act_val) begin
      errors++;
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
    end
  endtask

  task automatic end_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    errors++;
    $display("ERROR at %0t: %s", $time, what);
    end_run();
  endtask

  // One Wishbone cycle, ack sampled at the falling edge
  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
    int lat;
    @(posedge clk);
    wbs_cyc_i <= 1'b1;
    wbs_stb_i <= 1'b1;
    wbs_we_i  <= we;
    wbs_adr_i <= adr;
    wbs_dat_i <= wdat;
    wbs_sel_i <= 4'hf;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end while (!wbs_ack_o && lat < BUS_TIMEOUT);
    if (!wbs_ack_o) begin
      fail_timeout($sformatf("no bus acknowledge for address %h", adr));
    end else begin
      rdat = wbs_dat_o;
      check_value("wbs_ack_o latency", adr[`LED_MEM_SEL_BIT] ? `LED_MEM_LAT : 1, lat);
      @(posedge clk);
      wbs_cyc_i <= 1'b0;
      wbs_stb_i <= 1'b0;
      wbs_we_i  <= 1'b0;
    end
  endtask

  task automatic write_reg(input logic [1:0] idx, input logic [31:0] data);
    logic [31:0] discard;
    bus_access(1'b1, {28'd0, idx, 2'b00}, data, discard);
  endtask

  task automatic read_reg(input logic [1:0] idx, output logic [31:0] data);
    bus_access(1'b0, {28'd0, idx, 2'b00}, 32'd0, data);
  endtask

  task automatic write_byte(input int addr, input logic [31:0] data);
    logic [31:0] discard;
    bus_access(1'b1, MEM_BASE | (32'(addr) << 2), data, discard);
    fb_model[addr] = data[7:0];
  endtask

  task automatic set_config(input logic en, input logic irq_en, input logic idle);
    write_reg(led_pkg::REG_CONFIG, {en, irq_en, idle, 29'd0});
  endtask

  task automatic wait_progress_low();
    logic [31:0] rd;
    int          polls;
    polls = 0;
    do begin
      read_reg(led_pkg::REG_CTRL, rd);
      polls++;
    end while (rd[`LED_CTRL_PROG_BIT] && polls < POLL_LIMIT);
    if (rd[`LED_CTRL_PROG_BIT]) begin
      fail_timeout("progress bit never returned to 0");
    end
  endtask

  task automatic wait_rx_bytes(input int n);
    int cycles;
    cycles = 0;
    while (rx_bytes.size() < n && cycles < RX_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (rx_bytes.size() < n) begin
      fail_timeout("serial line delivered too few bytes");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequences
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_stream(input logic [15:0] mult, input logic [15:0] div, input logic idle,
                            input logic irq_en, input int count, input int first, input int len);
    logic [7:0]  expected [$];
    logic [31:0] rd;
    logic [31:0] ctrl;
    int          irq_base;
    int          scale;
    int          width;
    for (int a = first; a < first + len; a++) begin
      write_byte(a, $urandom());
    end
    for (int p = 0; p <= count; p++) begin
      for (int a = first; a < first + len; a++) begin
        expected.push_back(fb_model[a]);
      end
    end
    set_config(1'b0, irq_en, idle);     // Clears prescaler and encoder
    write_reg(led_pkg::REG_MULT, {16'd0, mult});
    write_reg(led_pkg::REG_DIV, {16'd0, div});
    set_config(1'b1, irq_en, idle);
    @(negedge clk);
    check_value("sout_o at rest", idle, sout_o);
    irq_base = irq_count;
    scale    = div / mult;
    rx_bytes.delete();
    rx_pulses.delete();
    line_idle <= idle;
    half_bit  <= (`LED_T_BIT / 2) * div / mult;
    decode_on <= 1'b1;
    ctrl = {1'b1, 2'b00, 4'(count), 3'b000, 10'(first + len - 1), 2'b00, 10'(first)};
    write_reg(led_pkg::REG_CTRL, ctrl);
    read_reg(led_pkg::REG_CTRL, rd);
    check_value("CTRL progress", 1, rd[`LED_CTRL_PROG_BIT]);
    check_value("CTRL range", ctrl & 32'h1E3F_F3FF, rd & 32'h1E3F_F3FF);
    wait_progress_low();
    wait_rx_bytes(expected.size());
    decode_on <= 1'b0;
    check_value("decoded byte count", expected.size(), rx_bytes.size());
    check_value("sout_o pulse count", 8 * expected.size(), rx_pulses.size());
    foreach (expected[i]) begin
      if (i < rx_bytes.size()) begin
        check_value($sformatf("sout_o byte %0d", i), expected[i], rx_bytes[i]);
      end
    end
    foreach (rx_pulses[i]) begin
      width = (rx_pulses[i] > half_bit) ? `LED_T_ONE * scale : `LED_T_ZERO * scale;
      check_value("sout_o pulse width", width, rx_pulses[i]);
    end
    check_value("irq_o pulses", irq_en, irq_count - irq_base);
  endtask

  // Clear enable while bits are still going out
  task automatic disable_midway(input logic idle);
    logic [31:0] rd;
    int          irq_base;
    int          cycles;
    for (int a = 100; a < 106; a++) begin
      write_byte(a, $urandom());
    end
    set_config(1'b0, 1'b0, idle);
    write_reg(led_pkg::REG_MULT, 32'd1);
    write_reg(led_pkg::REG_DIV, 32'd1);
    set_config(1'b1, 1'b0, idle);
    @(negedge clk);
    irq_base = irq_count;
    write_reg(led_pkg::REG_CTRL, {1'b1, 2'b00, 4'd2, 3'b000, 10'd105, 2'b00, 10'd100});
    read_reg(led_pkg::REG_CTRL, rd);
    check_value("CTRL progress", 1, rd[`LED_CTRL_PROG_BIT]);
    repeat (100 + $urandom_range(0, 1000)) @(posedge clk);
    set_config(1'b0, 1'b0, idle);
    read_reg(led_pkg::REG_CTRL, rd);
    check_value("CTRL progress after disable", 0, rd[`LED_CTRL_PROG_BIT]);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (sout_o !== idle && cycles < 4);
    check_value("sout_o after disable", idle, sout_o);
    check_value("irq_o pulses", 0, irq_count - irq_base);
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] data;
    logic [31:0] mask;
    int          idx;
    int          first;
    int          addr_q [$];
    void'($urandom(32'h5024_1e8a));
    rst_n     = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
    wbs_adr_i = '0;
    wbs_dat_i = '0;
    wbs_sel_i = '0;
    decode_on = 1'b0;
    line_idle = 1'b0;
    half_bit  = 12;
    run_len   = 0;
    rx_nbits  = 0;
    rx_shift  = '0;
    irq_count = 0;
    checks    = 0;
    errors    = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("wbs_ack_o after reset", 0, wbs_ack_o);
    check_value("irq_o after reset", 0, irq_o);
    check_value("sout_o after reset", 0, sout_o);

    // Register readback, unused bits read as zero
    for (int n = 0; n < 12; n++) begin
      idx  = $urandom_range(0, 3);
      data = $urandom();
      case (idx)
        0:       mask = 32'hE000_0000;
        1, 2:    mask = 32'h0000_FFFF;
        default: begin
          data[`LED_CTRL_GO_BIT] = 1'b0;   // No start here
          mask = 32'h1E3F_F3FF;
        end
      endcase
      write_reg(2'(idx), data);
      read_reg(2'(idx), rd);
      check_value($sformatf("wbs_dat_o register %0d", idx), data & mask, rd);
    end
    set_config(1'b0, 1'b0, 1'b0);

    // Frame buffer through the bus port
    for (int n = 0; n < 24; n++) begin
      first = $urandom_range(0, (1 << `LED_RAM_AW) - 1);
      addr_q.push_back(first);
      write_byte(first, $urandom());
    end
    foreach (addr_q[i]) begin
      bus_access(1'b0, MEM_BASE | (32'(addr_q[i]) << 2), 32'd0, rd);
      check_value("wbs_dat_o frame buffer", {24'd0, fb_model[addr_q[i]]}, rd);
    end

    for (int n = 0; n < 4; n++) begin
      data  = 1 + $urandom_range(0, 999);
      first = $urandom_range(0, 1018);
      run_stream(16'(data), 16'(data), 1'b0, n[0], $urandom_range(0, 2), first,
                 $urandom_range(1, 6));
    end
    first = $urandom_range(0, 1018);
    run_stream(16'd1, 16'd3, 1'b1, 1'b1, $urandom_range(0, 2), first, $urandom_range(1, 6));
    disable_midway(1'($urandom_range(0, 1)));
    end_run();
  end

endmodule

//--- src.f
+incdir+src
src/led_pkg.sv
src/led_prescaler.sv
src/led_bit_encoder.sv
src/led_sequencer.sv
src/led_frame_ram.sv
src/led_registers.sv
src/string_led_controller.sv
test/tb_string_led_controller.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 -Wno-fatal \
  --top-module tb_string_led_controller -f src.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
  exit 0
fi
exit 1
